// File: hw/video_timing_pkg.sv
package video_timing_pkg;

    // Timing standard chosen by the host at run time
    typedef enum logic {
        PAL  = 1'b0,
        NTSC = 1'b1
    } video_mode_t;

    // Counter widths cover the longer standard
    localparam int hc_width = 9;
    localparam int vc_width = 9;

    //////////////////////////////////////////////////////////////////////
    // Horizontal timing in 7 MHz pixel clocks
    //////////////////////////////////////////////////////////////////////

    localparam logic [hc_width-1:0] pal_line_clocks  = hc_width'(448);
    localparam logic [hc_width-1:0] ntsc_line_clocks = hc_width'(456);
    localparam logic [hc_width-1:0] active_clocks    = hc_width'(352);

    // Same sync pulse position and length in both standards
    localparam logic [hc_width-1:0] hsync_start = hc_width'(376);
    localparam logic [hc_width-1:0] hsync_len   = hc_width'(32);

    //////////////////////////////////////////////////////////////////////
    // Vertical timing in lines
    //////////////////////////////////////////////////////////////////////

    localparam logic [vc_width-1:0] pal_frame_lines   = vc_width'(312);
    localparam logic [vc_width-1:0] ntsc_frame_lines  = vc_width'(262);
    localparam logic [vc_width-1:0] pal_active_lines  = vc_width'(288);
    localparam logic [vc_width-1:0] ntsc_active_lines = vc_width'(240);

    // Vertical sync lines as an inclusive range
    localparam logic [vc_width-1:0] pal_vsync_first  = vc_width'(296);
    localparam logic [vc_width-1:0] pal_vsync_last   = vc_width'(299);
    localparam logic [vc_width-1:0] ntsc_vsync_first = vc_width'(248);
    localparam logic [vc_width-1:0] ntsc_vsync_last  = vc_width'(250);

    // Per-mode selectors
    function automatic logic [hc_width-1:0] line_last(input video_mode_t mode);
        return (mode == NTSC) ? ntsc_line_clocks - 1'b1 : pal_line_clocks - 1'b1;
    endfunction

    function automatic logic [vc_width-1:0] frame_last(input video_mode_t mode);
        return (mode == NTSC) ? ntsc_frame_lines - 1'b1 : pal_frame_lines - 1'b1;
    endfunction

    function automatic logic [vc_width-1:0] active_lines(input video_mode_t mode);
        return (mode == NTSC) ? ntsc_active_lines : pal_active_lines;
    endfunction

    function automatic logic [vc_width-1:0] vsync_first(input video_mode_t mode);
        return (mode == NTSC) ? ntsc_vsync_first : pal_vsync_first;
    endfunction

    function automatic logic [vc_width-1:0] vsync_last(input video_mode_t mode);
        return (mode == NTSC) ? ntsc_vsync_last : pal_vsync_last;
    endfunction

endpackage

// File: hw/pixel_pkg.sv
package pixel_pkg;

    // Bits per colour channel, and one RGB pixel packed as {r, g, b}
    localparam int colour_width = 3;
    localparam int pixel_width  = 3 * colour_width;

    //////////////////////////////////////////////////////////////////////
    // Colour bar geometry
    //////////////////////////////////////////////////////////////////////

    localparam int bar_clocks      = 44;
    localparam int bar_count       = 8;
    localparam int bar_index_width = $clog2(bar_count);

    // Channel levels
    localparam logic [colour_width-1:0] chan_off  = {colour_width{1'b0}};
    localparam logic [colour_width-1:0] chan_full = {colour_width{1'b1}};

    // Black pixel for everything outside the active area
    localparam logic [pixel_width-1:0] pixel_black = {chan_off, chan_off, chan_off};

    // Binary GRB order
    // index bit 2 is green, bit 1 red, bit 0 blue
    localparam logic [pixel_width-1:0] bar_colours [bar_count] = '{
        {chan_off,  chan_off,  chan_off},    // black
        {chan_off,  chan_off,  chan_full},   // blue
        {chan_full, chan_off,  chan_off},    // red
        {chan_full, chan_off,  chan_full},   // magenta
        {chan_off,  chan_full, chan_off},    // green
        {chan_off,  chan_full, chan_full},   // cyan
        {chan_full, chan_full, chan_off},    // yellow
        {chan_full, chan_full, chan_full}    // white
    };

endpackage

// File: hw/raster_control.sv
`timescale 1ns/1ps

module raster_control (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  mode_req,
    input  video_timing_pkg::video_mode_t         mode_sel,
    output logic                                  mode_ack,
    output logic [video_timing_pkg::hc_width-1:0] hc,
    output logic [video_timing_pkg::vc_width-1:0] vc,
    output logic                                  blank,
    output video_timing_pkg::video_mode_t         active_mode
);

    import video_timing_pkg::*;

    // Mode handshake states
    typedef enum logic [1:0] {
        st_idle,
        st_wait_frame,
        st_ack
    } hs_state_t;

    hs_state_t           state;
    hs_state_t           state_next;
    logic                hc_last;
    logic                vc_last;
    logic                frame_end;
    logic [hc_width-1:0] hc_next;
    logic [vc_width-1:0] vc_next;
    video_mode_t         mode_next;
    logic                blank_next;

    //////////////////////////////////////////////////////////////////////
    // Raster counters
    //////////////////////////////////////////////////////////////////////

    // Wrap points follow the mode in force
    always_comb begin
        hc_last   = (hc == line_last(active_mode));
        vc_last   = (vc == frame_last(active_mode));
        frame_end = hc_last && vc_last;
    end

    always_comb begin
        hc_next = hc + 1'b1;
        vc_next = vc;
        if (hc_last) begin
            hc_next = '0;
            vc_next = vc_last ? '0 : vc + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Mode handshake
    //////////////////////////////////////////////////////////////////////

    // Mode only swaps on the frame wrap, so the raster never tears
    always_comb begin
        state_next = state;
        mode_next  = active_mode;
        case (state)
            st_idle: begin
                if (mode_req) begin
                    state_next = st_wait_frame;
                end
            end
            st_wait_frame: begin
                if (frame_end) begin
                    state_next = st_ack;
                    mode_next  = mode_sel;
                end
            end
            st_ack: begin
                // Hold ack until the host lets go of req
                if (!mode_req) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // Blanking for the position the counters move to next
    always_comb begin
        blank_next = (hc_next >= active_clocks) || (vc_next >= active_lines(mode_next));
    end

    //////////////////////////////////////////////////////////////////////
    // State registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            hc          <= '0;
            vc          <= '0;
            blank       <= 1'b0;
            active_mode <= PAL;
            state       <= st_idle;
            mode_ack    <= 1'b0;
        end else begin
            hc          <= hc_next;
            vc          <= vc_next;
            blank       <= blank_next;
            active_mode <= mode_next;
            state       <= state_next;
            mode_ack    <= (state_next == st_ack);
        end
    end

endmodule

// File: hw/csync_shaper.sv
`timescale 1ns/1ps

module csync_shaper (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [video_timing_pkg::hc_width-1:0] hc,
    input  logic [video_timing_pkg::vc_width-1:0] vc,
    input  video_timing_pkg::video_mode_t         active_mode,
    output logic                                  csync_n
);

    import video_timing_pkg::*;

    logic [vc_width-1:0] vs_first;
    logic [vc_width-1:0] vs_last;
    logic                hsync;
    logic                vsync;
    logic                csync_n_next;

    //////////////////////////////////////////////////////////////////////
    // Sync decode
    //////////////////////////////////////////////////////////////////////

    // Horizontal pulse window is identical for PAL and NTSC
    always_comb begin
        hsync = (hc >= hsync_start) && (hc < hsync_start + hsync_len);
    end

    // Sync lines depend on the standard in force
    always_comb begin
        vs_first = vsync_first(active_mode);
        vs_last  = vsync_last(active_mode);
        vsync    = (vc >= vs_first) && (vc <= vs_last);
    end

    // No serration or equalisation
    // during vsync lines the line sync is simply inverted
    always_comb begin
        csync_n_next = ~(hsync ^ vsync);
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    // A single stage keeps sync in line with the colour output
    always_ff @(posedge clk) begin
        if (rst) begin
            csync_n <= 1'b1;
        end else begin
            csync_n <= csync_n_next;
        end
    end

endmodule

// File: hw/bar_pattern.sv
`timescale 1ns/1ps

module bar_pattern (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [video_timing_pkg::hc_width-1:0] hc,
    input  logic                                  blank,
    output logic [pixel_pkg::colour_width-1:0]    r,
    output logic [pixel_pkg::colour_width-1:0]    g,
    output logic [pixel_pkg::colour_width-1:0]    b
);

    import video_timing_pkg::*;
    import pixel_pkg::*;

    logic [bar_index_width-1:0] bar_idx;
    logic [pixel_width-1:0]     colour;

    // Bar index steps once every bar_clocks
    // saturates at the last bar past the active area
    always_comb begin
        bar_idx = '0;
        for (int i = 1; i < bar_count; i++) begin
            if (hc >= hc_width'(i * bar_clocks)) begin
                bar_idx = bar_index_width'(i);
            end
        end
    end

    // Black outside the active area
    always_comb begin
        colour = blank ? pixel_black : bar_colours[bar_idx];
    end

    // Single pipeline stage
    always_ff @(posedge clk) begin
        if (rst) begin
            r <= '0;
            g <= '0;
            b <= '0;
        end else begin
            r <= colour[pixel_width-1 -: colour_width];
            g <= colour[2*colour_width-1 -: colour_width];
            b <= colour[colour_width-1:0];
        end
    end

endmodule

// File: hw/test_card_top.sv
`timescale 1ns/1ps

module test_card_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               mode_req,
    input  video_timing_pkg::video_mode_t      mode_sel,
    output logic                               mode_ack,
    output logic [pixel_pkg::colour_width-1:0] r,
    output logic [pixel_pkg::colour_width-1:0] g,
    output logic [pixel_pkg::colour_width-1:0] b,
    output logic                               csync_n
);

    import video_timing_pkg::*;

    // Raster position and mode shared by both datapath blocks
    logic [hc_width-1:0] hc;
    logic [vc_width-1:0] vc;
    logic                blank;
    video_mode_t         active_mode;

    raster_control raster_control_inst (
        .clk         (clk),
        .rst         (rst),
        .mode_req    (mode_req),
        .mode_sel    (mode_sel),
        .mode_ack    (mode_ack),
        .hc          (hc),
        .vc          (vc),
        .blank       (blank),
        .active_mode (active_mode)
    );

    // Both blocks register once, so colour and sync stay aligned
    csync_shaper csync_shaper_inst (
        .clk         (clk),
        .rst         (rst),
        .hc          (hc),
        .vc          (vc),
        .active_mode (active_mode),
        .csync_n     (csync_n)
    );

    bar_pattern bar_pattern_inst (
        .clk   (clk),
        .rst   (rst),
        .hc    (hc),
        .blank (blank),
        .r     (r),
        .g     (g),
        .b     (b)
    );

endmodule

// File: tests/test_card_tb.sv
`timescale 1ns/1ps

module test_card_tb;

    import video_timing_pkg::*;
    import pixel_pkg::*;

    // Reference figures for the two standards in clocks and lines
    localparam int clk_period_ns    = 8;
    localparam int reset_cycles     = 8;
    localparam int pal_line_len     = 448;
    localparam int ntsc_line_len    = 456;
    localparam int pal_lines        = 312;
    localparam int ntsc_lines       = 262;
    localparam int pal_vs_first     = 296;
    localparam int pal_vs_lines     = 4;
    localparam int ntsc_vs_lines    = 3;
    localparam int vis_clocks       = 352;
    localparam int sync_pulse_len   = 32;
    localparam int bar_len          = 44;
    localparam int pal_frame_clocks = pal_line_len * pal_lines;

    // Bounds for every wait
    localparam int run_limit     = 1000;
    localparam int search_lines  = 1000;
    localparam int ack_limit     = pal_frame_clocks + 64;

    // Several times the length of the whole test sequence
    localparam int watchdog_frames = 18;
    localparam int watchdog_ns     = watchdog_frames * pal_frame_clocks * clk_period_ns;

    logic                    clk;
    logic                    rst;
    logic                    mode_req;
    video_mode_t             mode_sel;
    logic                    mode_ack;
    logic [colour_width-1:0] r;
    logic [colour_width-1:0] g;
    logic [colour_width-1:0] b;
    logic                    csync_n;

    int cycle  = 0;
    int checks = 0;
    int errors = 0;

    test_card_top test_card_top_inst (
        .clk      (clk),
        .rst      (rst),
        .mode_req (mode_req),
        .mode_sel (mode_sel),
        .mode_ack (mode_ack),
        .r        (r),
        .g        (g),
        .b        (b),
        .csync_n  (csync_n)
    );

    always #(clk_period_ns / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks and helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_colour(input string name, input logic [colour_width-1:0] expected,
                                input logic [colour_width-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch in %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("mismatch in %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_mode(input string name, input video_mode_t expected,
                              input video_mode_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch in %s: expected %s, actual %s", name, expected.name(),
                     actual.name());
        end
    endtask

    // Drive and sample 1 ns after the rising edge
    task automatic next_clock();
        @(posedge clk);
        #1;
    endtask

    // Red on bit 1, green on bit 2 and blue on bit 0 of the bar index
    function automatic logic [3*colour_width-1:0] bar_rgb(input int idx);
        logic [colour_width-1:0] full;
        logic [colour_width-1:0] red;
        logic [colour_width-1:0] green;
        logic [colour_width-1:0] blue;
        full  = '1;
        red   = idx[1] ? full : '0;
        green = idx[2] ? full : '0;
        blue  = idx[0] ? full : '0;
        return {red, green, blue};
    endfunction

    task automatic measure_csync(input logic level, output int len);
        len = 0;
        while (csync_n == level && len < run_limit) begin
            len++;
            next_clock();
        end
        if (len == run_limit) begin
            errors++;
            $display("csync_n stayed at %b for more than %0d clocks", level, run_limit);
        end
    endtask

    task automatic measure_colour(input logic [3*colour_width-1:0] want, output int len);
        len = 0;
        while ({r, g, b} == want && len < run_limit) begin
            len++;
            next_clock();
        end
        if (len == run_limit) begin
            errors++;
            $display("colour %h held for more than %0d clocks", want, run_limit);
        end
    endtask

    // One sync pulse width and the distance between two falling edges
    task automatic line_timing(input string name, input int line_len);
        int t0;
        int low_len;
        int high_len;
        measure_csync(1'b0, low_len);
        measure_csync(1'b1, high_len);
        t0 = cycle;
        measure_csync(1'b0, low_len);
        measure_csync(1'b1, high_len);
        check_count({name, " sync pulse"}, sync_pulse_len, low_len);
        check_count({name, " line period"}, line_len, cycle - t0);
    endtask

    // Vsync starts where a long high run meets a long low run
    // inside the region every high run is a 32-clock line pulse
    task automatic find_vsync(input int long_len, output int start, output int span,
                              output int longs);
        int  high_len;
        int  low_len;
        int  iter;
        logic found;
        logic done;
        start = 0;
        span  = 0;
        longs = 0;
        found = 1'b0;
        done  = 1'b0;
        iter  = 0;
        measure_csync(1'b0, low_len);
        while (!found && iter < search_lines) begin
            measure_csync(1'b1, high_len);
            start = cycle;
            measure_csync(1'b0, low_len);
            found = (high_len > sync_pulse_len) && (low_len > sync_pulse_len);
            iter++;
        end
        if (!found) begin
            errors++;
            $display("no vertical sync region found within %0d lines", search_lines);
        end else begin
            iter = 0;
            while (!done && iter < 16) begin
                measure_csync(1'b1, high_len);
                if (high_len > sync_pulse_len) begin
                    span = cycle - high_len - start;
                    done = 1'b1;
                end else begin
                    measure_csync(1'b0, low_len);
                    if (low_len == long_len) begin
                        longs++;
                    end
                end
                iter++;
            end
        end
    endtask

    task automatic frame_timing(input string name, input int line_len, input int lines,
                                input int vs_lines);
        int start0;
        int start1;
        int span;
        int longs;
        find_vsync(line_len - sync_pulse_len, start0, span, longs);
        check_count({name, " vsync span"}, vs_lines * line_len, span);
        check_count({name, " long low count"}, vs_lines - 1, longs);
        find_vsync(line_len - sync_pulse_len, start1, span, longs);
        check_count({name, " vsync span"}, vs_lines * line_len, span);
        check_count({name, " frame period"}, lines * line_len, start1 - start0);
    endtask

    // Four-phase handshake where the new mode lands on hc = 0 and vc = 0
    task automatic request_mode(input string name, input video_mode_t mode);
        int waited;
        mode_sel = mode;
        next_clock();
        mode_req = 1'b1;
        waited = 0;
        while (!mode_ack && waited < ack_limit) begin
            next_clock();
            waited++;
        end
        if (!mode_ack) begin
            errors++;
            $display("%s: mode_ack did not rise within %0d clocks of mode_req", name,
                     ack_limit);
            mode_req = 1'b0;
        end else begin
            check_mode(name, mode, test_card_top_inst.raster_control_inst.active_mode);
            check_count({name, " hc at ack"}, 0, int'(test_card_top_inst.raster_control_inst.hc));
            check_count({name, " vc at ack"}, 0, int'(test_card_top_inst.raster_control_inst.vc));
            mode_req = 1'b0;
            next_clock();
            check_count({name, " ack release"}, 0, int'(mode_ack));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_state_test();
        repeat (reset_cycles) begin
            next_clock();
            check_colour("reset_state r", '0, r);
            check_colour("reset_state g", '0, g);
            check_colour("reset_state b", '0, b);
            check_count("reset_state csync_n", 1, int'(csync_n));
        end
        rst = 1'b0;
        next_clock();
        check_colour("after_reset r", '0, r);
        check_colour("after_reset g", '0, g);
        check_colour("after_reset b", '0, b);
        check_count("after_reset csync_n", 1, int'(csync_n));
    endtask

    task automatic colour_bar_test();
        int start;
        int span;
        int longs;
        int len;
        int waited;
        int i;
        logic [3*colour_width-1:0] want;
        find_vsync(pal_line_len - sync_pulse_len, start, span, longs);
        waited = 0;
        while ({r, g, b} == bar_rgb(0) && waited < pal_frame_clocks) begin
            next_clock();
            waited++;
        end
        if ({r, g, b} == bar_rgb(0)) begin
            errors++;
            $display("no coloured pixel appeared after vertical sync");
        end else begin
            // Lines after vsync stay black until bar 1 of the next frame
            check_count("colour_bars first blue after vsync",
                        (pal_lines - pal_vs_first) * pal_line_len + bar_len, cycle - start);
            for (i = 1; i < 8; i++) begin
                want = bar_rgb(i);
                check_colour($sformatf("colour_bars bar %0d red", i), want[8:6], r);
                check_colour($sformatf("colour_bars bar %0d green", i), want[5:3], g);
                check_colour($sformatf("colour_bars bar %0d blue", i), want[2:0], b);
                measure_colour(want, len);
                check_count($sformatf("colour_bars bar %0d width", i), bar_len, len);
            end
            // Right blanking runs straight into the black first bar
            measure_colour(bar_rgb(0), len);
            check_count("colour_bars black run", (pal_line_len - vis_clocks) + bar_len, len);
        end
    endtask

    task automatic pal_line_test();
        line_timing("pal_line", pal_line_len);
        line_timing("pal_line", pal_line_len);
    endtask

    task automatic pal_frame_test();
        frame_timing("pal_frame", pal_line_len, pal_lines, pal_vs_lines);
    endtask

    task automatic mode_switch_test();
        request_mode("mode_switch ntsc", NTSC);
        line_timing("ntsc_line", ntsc_line_len);
        frame_timing("ntsc_frame", ntsc_line_len, ntsc_lines, ntsc_vs_lines);
        request_mode("mode_switch pal", PAL);
        line_timing("pal_line after switch", pal_line_len);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        mode_req = 1'b0;
        mode_sel = PAL;
        reset_state_test();
        colour_bar_test();
        pal_line_test();
        pal_frame_test();
        mode_switch_test();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, tests did not finish", watchdog_ns);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the test-card testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=test_card_tb
file_list=test_card_top.f
build_dir=obj_dir
log=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --top-module "$top" -f "$file_list" --Mdir "$build_dir"
status=$?
if [ "$status" -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

"./$build_dir/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$log"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $log"
exit 1

// File: test_card_top.f
hw/video_timing_pkg.sv
hw/pixel_pkg.sv
hw/raster_control.sv
hw/csync_shaper.sv
hw/bar_pattern.sv
hw/test_card_top.sv
tests/test_card_tb.sv
